//--- project.f
src/fpss_pkg.sv
src/fpss_exec_if.sv
src/fpss_wb_if.sv
src/fpss_cfg_apb.sv
src/fpss_scoreboard.sv
src/fpss_regfile.sv
src/fpss_issue.sv
src/fpss_exec_pipe.sv
src/fpss_top.sv
tests/fpss_clk_gen.sv
tests/fpss_tb.sv

//--- tests/fpss_tb.sv
`timescale 1ns/1ps

module fpss_tb;
    import fpss_pkg::*;

    localparam int REQ_TIMEOUT = 100;
    localparam int RSP_TIMEOUT = 100;
    localparam int APB_TIMEOUT = 10;

    logic              clk;
    logic              rst_n;
    logic [31:0]       req_instr;
    logic [ID_W-1:0]   req_id;
    logic [XLEN-1:0]   req_arg;
    logic              req_valid;
    logic              req_ready;
    logic [ID_W-1:0]   rsp_id;
    logic [XLEN-1:0]   rsp_data;
    logic              rsp_error;
    logic              rsp_valid;
    logic              rsp_ready;
    logic [CFG_ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;

    int                err_cnt;
    int                check_cnt;
    int                timeout_cnt;
    logic [31:0]       rng_state;
    logic [ID_W-1:0]   next_id;

    // Reference state: offsets and physical registers
    logic [OFFS_W-1:0] offs [NUM_OFFS];
    logic [31:0]       model_val [2**PADDR_W];
    logic              model_boxed [2**PADDR_W];

    logic [31:0]       burst_instr [8];
    logic [ID_W-1:0]   burst_id [8];
    logic [31:0]       burst_arg [8];
    logic [31:0]       burst_data [8];

    fpss_clk_gen clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fpss_top uut (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .acc_req_instr_i (req_instr),
        .acc_req_id_i    (req_id),
        .acc_req_arg_i   (req_arg),
        .acc_req_valid_i (req_valid),
        .acc_req_ready_o (req_ready),
        .acc_rsp_id_o    (rsp_id),
        .acc_rsp_data_o  (rsp_data),
        .acc_rsp_error_o (rsp_error),
        .acc_rsp_valid_o (rsp_valid),
        .acc_rsp_ready_i (rsp_ready),
        .paddr_i         (paddr),
        .psel_i          (psel),
        .penable_i       (penable),
        .pwrite_i        (pwrite),
        .pwdata_i        (pwdata),
        .prdata_o        (prdata),
        .pready_o        (pready),
        .pslverr_o       (pslverr)
    );

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    function logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [PADDR_W-1:0] phys(input logic [NAME_W-1:0] name);
        return {offs[name[4:3]], name[2:0]};
    endfunction

    // Unboxed or never written reads as canonical NaN
    function automatic logic [31:0] read_single(input logic [PADDR_W-1:0] p);
        if (model_boxed[p]) begin
            return model_val[p];
        end else begin
            return CANON_NAN;
        end
    endfunction

    function automatic logic [31:0] make_instr(input logic [3:0] op,
                                               input logic [4:0] rd, rs1, rs2);
        return {op, rd, rs1, rs2, 13'd0};
    endfunction

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Expected response and register update from the operation rules
    task automatic predict(input logic [3:0] op, input logic [4:0] rd, rs1, rs2,
                           input logic [31:0] arg, output logic [31:0] exp_data,
                           output logic exp_err);
        logic [31:0] a;
        logic [31:0] b;
        a = read_single(phys(rs1));
        b = read_single(phys(rs2));
        exp_err = 1'b0;
        case (op)
            OP_FSGNJ:   exp_data = {b[31], a[30:0]};
            OP_FSGNJN:  exp_data = {~b[31], a[30:0]};
            OP_FSGNJX:  exp_data = {a[31] ^ b[31], a[30:0]};
            OP_FMV_W_X: exp_data = arg;
            OP_FMV_X_W: exp_data = a;
            default: begin
                exp_data = '0;
                exp_err  = 1'b1;
            end
        endcase
        if (!exp_err && op != OP_FMV_X_W) begin
            model_val[phys(rd)]   = exp_data;
            model_boxed[phys(rd)] = 1'b1;
        end
    endtask

    task automatic send_req(input logic [31:0] instr, input logic [ID_W-1:0] id,
                            input logic [31:0] arg);
        int   cnt;
        logic accepted;
        req_instr = instr;
        req_id    = id;
        req_arg   = arg;
        req_valid = 1'b1;
        cnt       = 0;
        accepted  = 1'b0;
        while (!accepted && cnt < REQ_TIMEOUT) begin
            @(negedge clk);
            accepted = req_ready;
            @(posedge clk);
            #1;
            cnt++;
        end
        req_valid = 1'b0;
        if (!accepted) begin
            timeout_cnt++;
            $display("Timeout: request %h was not accepted in %0d cycles", instr, cnt);
        end
    endtask

    task automatic get_rsp(output logic [ID_W-1:0] id, output logic [31:0] data,
                           output logic err);
        int   cnt;
        logic seen;
        rsp_ready = 1'b1;
        cnt       = 0;
        seen      = 1'b0;
        while (!seen && cnt < RSP_TIMEOUT) begin
            @(negedge clk);
            seen = rsp_valid;
            id   = rsp_id;
            data = rsp_data;
            err  = rsp_error;
            @(posedge clk);
            #1;
            cnt++;
        end
        rsp_ready = 1'b0;
        if (!seen) begin
            timeout_cnt++;
            $display("Timeout: no response arrived in %0d cycles", cnt);
        end
    endtask

    task automatic apb_xfer(input logic write, input logic [CFG_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
        int   cnt;
        logic done;
        paddr   = addr;
        pwdata  = wdata;
        pwrite  = write;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        cnt     = 0;
        done    = 1'b0;
        while (!done && cnt < APB_TIMEOUT) begin
            @(negedge clk);
            done   = pready;
            rdata  = prdata;
            slverr = pslverr;
            @(posedge clk);
            #1;
            cnt++;
        end
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        if (!done) begin
            timeout_cnt++;
            $display("Timeout: APB transfer to address %h never completed", addr);
        end
    endtask

    task automatic apb_write(input logic [CFG_ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic slverr);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apb_read(input logic [CFG_ADDR_W-1:0] addr, output logic [31:0] data);
        logic slverr;
        apb_xfer(1'b0, addr, 32'd0, data, slverr);
        check_equal(slverr, 1'b0, "APB read error flag");
    endtask

    // One request and its response, checked against the reference
    task automatic exec_op(input logic [3:0] op, input logic [4:0] rd, rs1, rs2,
                           input logic [31:0] arg, output logic [31:0] data);
        logic [31:0]     exp_data;
        logic            exp_err;
        logic [ID_W-1:0] id;
        logic [ID_W-1:0] got_id;
        logic            got_err;
        id      = next_id;
        next_id = next_id + 1'b1;
        predict(op, rd, rs1, rs2, arg, exp_data, exp_err);
        send_req(make_instr(op, rd, rs1, rs2), id, arg);
        get_rsp(got_id, data, got_err);
        check_equal(got_id, id, "response id");
        check_equal(got_err, exp_err, "response error");
        check_equal(data, exp_data, "response data");
    endtask

    task automatic queue_burst(input int k, input logic [3:0] op,
                               input logic [4:0] rd, rs1, rs2, input logic [31:0] arg);
        logic unused_err;
        burst_id[k]    = next_id;
        next_id        = next_id + 1'b1;
        burst_arg[k]   = arg;
        burst_instr[k] = make_instr(op, rd, rs1, rs2);
        predict(op, rd, rs1, rs2, arg, burst_data[k], unused_err);
    endtask

    // Sender and receiver run together, responses blocked for 20 cycles
    task automatic run_blocked(input int n, input int early_exp);
        int              sent;
        logic [ID_W-1:0] got_id;
        logic [31:0]     data;
        logic            got_err;
        sent = 0;
        fork
            begin
                for (int k = 0; k < n; k++) begin
                    send_req(burst_instr[k], burst_id[k], burst_arg[k]);
                    sent++;
                end
            end
            begin
                repeat (19) @(posedge clk);
                @(negedge clk);
                check_equal(sent, early_exp, "requests accepted while blocked");
                @(posedge clk);
                #1;
                for (int k = 0; k < n; k++) begin
                    get_rsp(got_id, data, got_err);
                    check_equal(got_id, burst_id[k], "burst response id");
                    check_equal(data, burst_data[k], "burst response data");
                    check_equal(got_err, 1'b0, "burst response error");
                end
            end
        join
        // No duplicate left behind
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            check_equal(rsp_valid, 1'b0, "unexpected extra response");
        end
        @(posedge clk);
        #1;
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic move_round_trip();
        logic [31:0] data;
        for (int n = 0; n < 32; n++) begin
            exec_op(OP_FMV_W_X, 5'(n), 5'd0, 5'd0, next_rand(), data);
        end
        for (int n = 0; n < 32; n++) begin
            exec_op(OP_FMV_X_W, 5'd0, 5'(n), 5'd0, 32'd0, data);
        end
    endtask

    task automatic sign_injection();
        logic [31:0] data;
        logic [31:0] arg;
        logic        slverr;
        // Names 24 to 31 onto registers 40 to 47, never written
        apb_write(4'hC, 32'd5, slverr);
        offs[3] = 3'd5;
        for (int n = 1; n <= 6; n++) begin
            arg     = next_rand();
            arg[31] = n[0];
            exec_op(OP_FMV_W_X, 5'(n), 5'd0, 5'd0, arg, data);
        end
        exec_op(OP_FMV_X_W, 5'd0, 5'd24, 5'd0, 32'd0, data);
        check_equal(data, 32'h7FC0_0000, "unwritten register");
        exec_op(OP_FSGNJ, 5'd7, 5'd1, 5'd2, 32'd0, data);
        exec_op(OP_FSGNJN, 5'd8, 5'd3, 5'd4, 32'd0, data);
        exec_op(OP_FSGNJX, 5'd9, 5'd5, 5'd6, 32'd0, data);
        exec_op(OP_FSGNJ, 5'd10, 5'd24, 5'd1, 32'd0, data);
        exec_op(OP_FSGNJN, 5'd11, 5'd2, 5'd24, 32'd0, data);
        exec_op(OP_FSGNJX, 5'd12, 5'd1, 5'd24, 32'd0, data);
        for (int n = 7; n <= 12; n++) begin
            exec_op(OP_FMV_X_W, 5'd0, 5'(n), 5'd0, 32'd0, data);
        end
        apb_write(4'hC, 32'd3, slverr);
        offs[3] = 3'd3;
    endtask

    task automatic offset_translation();
        logic [31:0] data;
        logic [31:0] v;
        logic        slverr;
        apb_write(4'h4, 32'(offs[0]), slverr);
        check_equal(slverr, 1'b0, "offset write error flag");
        offs[1] = offs[0];
        apb_read(4'h4, data);
        check_equal(data, 32'(offs[0]), "offset 1 readback");
        v = next_rand();
        exec_op(OP_FMV_W_X, 5'd3, 5'd0, 5'd0, v, data);
        exec_op(OP_FMV_X_W, 5'd0, 5'd11, 5'd0, 32'd0, data);
        check_equal(data, v, "name 11 aliases name 3");
        // Unaligned addresses are unmapped
        apb_write(4'h6, 32'd7, slverr);
        check_equal(slverr, 1'b1, "unaligned write error flag");
        apb_write(4'hD, 32'd6, slverr);
        check_equal(slverr, 1'b1, "unaligned write error flag");
        for (int k = 0; k < NUM_OFFS; k++) begin
            apb_read(4'(4 * k), data);
            check_equal(data, 32'(offs[k]), "offset unchanged after error");
        end
        apb_write(4'h4, 32'd1, slverr);
        offs[1] = 3'd1;
    endtask

    task automatic hazard_back_pressure();
        logic [31:0] data;
        exec_op(OP_FMV_W_X, 5'd12, 5'd0, 5'd0, next_rand(), data);
        exec_op(OP_FMV_W_X, 5'd13, 5'd0, 5'd0, next_rand(), data);
        // Each step reads the previous destination
        queue_burst(0, OP_FSGNJ, 5'd14, 5'd12, 5'd13, 32'd0);
        queue_burst(1, OP_FSGNJN, 5'd15, 5'd14, 5'd13, 32'd0);
        queue_burst(2, OP_FSGNJX, 5'd16, 5'd15, 5'd14, 32'd0);
        queue_burst(3, OP_FSGNJ, 5'd17, 5'd16, 5'd15, 32'd0);
        queue_burst(4, OP_FMV_X_W, 5'd0, 5'd17, 5'd0, 32'd0);
        run_blocked(5, 1);
        // Three fit in the pipeline, the fourth waits for a drain
        for (int k = 0; k < 4; k++) begin
            queue_burst(k, OP_FMV_W_X, 5'(20 + k), 5'd0, 5'd0, next_rand());
        end
        run_blocked(4, 3);
        for (int n = 20; n < 24; n++) begin
            exec_op(OP_FMV_X_W, 5'd0, 5'(n), 5'd0, 32'd0, data);
        end
    endtask

    task automatic illegal_opcode();
        logic [31:0] data;
        for (int op = 0; op < 16; op++) begin
            if (op < 1 || op > 5) begin
                exec_op(4'(op), 5'd5, 5'd6, 5'd7, next_rand(), data);
            end
        end
        exec_op(OP_FMV_X_W, 5'd0, 5'd5, 5'd0, 32'd0, data);
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int cnt;
        req_instr   = '0;
        req_id      = '0;
        req_arg     = '0;
        req_valid   = 1'b0;
        rsp_ready   = 1'b0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        err_cnt     = 0;
        check_cnt   = 0;
        timeout_cnt = 0;
        rng_state   = 32'd77;
        next_id     = '0;
        for (int k = 0; k < NUM_OFFS; k++) begin
            offs[k] = 3'(k);
        end
        for (int p = 0; p < 2**PADDR_W; p++) begin
            model_val[p]   = '0;
            model_boxed[p] = 1'b0;
        end

        cnt = 0;
        while (!rst_n && cnt < 50) begin
            @(negedge clk);
            cnt++;
            if (!rst_n) begin
                check_equal(req_ready, 1'b0, "request ready in reset");
                check_equal(rsp_valid, 1'b0, "response valid in reset");
                check_equal(pready, 1'b0, "pready in reset");
                check_equal(pslverr, 1'b0, "pslverr in reset");
            end
        end
        if (!rst_n) begin
            timeout_cnt++;
            $display("Timeout: reset was never released");
        end
        @(posedge clk);
        #1;

        move_round_trip();
        sign_injection();
        offset_translation();
        hazard_back_pressure();
        illegal_opcode();

        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tests/fpss_clk_gen.sv
`timescale 1ns/1ps

module fpss_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Reset held over 8 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (8) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

//--- src/fpss_top.sv
`timescale 1ns/1ps

module fpss_top (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [31:0]                      acc_req_instr_i,
    input  logic [fpss_pkg::ID_W-1:0]        acc_req_id_i,
    input  logic [fpss_pkg::XLEN-1:0]        acc_req_arg_i,
    input  logic                             acc_req_valid_i,
    output logic                             acc_req_ready_o,
    output logic [fpss_pkg::ID_W-1:0]        acc_rsp_id_o,
    output logic [fpss_pkg::XLEN-1:0]        acc_rsp_data_o,
    output logic                             acc_rsp_error_o,
    output logic                             acc_rsp_valid_o,
    input  logic                             acc_rsp_ready_i,
    input  logic [fpss_pkg::CFG_ADDR_W-1:0]  paddr_i,
    input  logic                             psel_i,
    input  logic                             penable_i,
    input  logic                             pwrite_i,
    input  logic [31:0]                      pwdata_i,
    output logic [31:0]                      prdata_o,
    output logic                             pready_o,
    output logic                             pslverr_o
);
    import fpss_pkg::*;

    logic [NUM_OFFS-1:0][OFFS_W-1:0] offsets;
    logic [PADDR_W-1:0]              raddr_a;
    logic [PADDR_W-1:0]              raddr_b;
    fpss_reg_u                       rdata_a;
    fpss_reg_u                       rdata_b;
    logic                            sb_push;
    logic [PADDR_W-1:0]              sb_push_addr;
    logic [SB_IDX_W-1:0]             sb_idx;
    logic [2:0][PADDR_W-1:0]         sb_test_addrs;
    logic [2:0]                      sb_test_en;
    logic                            sb_collision;
    logic                            sb_full;

    fpss_exec_if ex_if ();
    fpss_wb_if   wb_if ();

    fpss_cfg_apb i_cfg (
        .clk_i, .rst_n_i,
        .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .offsets_o (offsets)
    );

    fpss_issue i_issue (
        .acc_req_instr_i, .acc_req_id_i, .acc_req_arg_i,
        .acc_req_valid_i, .acc_req_ready_o,
        .offsets_i       (offsets),
        .raddr_a_o       (raddr_a),
        .raddr_b_o       (raddr_b),
        .rdata_a_i       (rdata_a),
        .rdata_b_i       (rdata_b),
        .sb_push_o       (sb_push),
        .sb_push_addr_o  (sb_push_addr),
        .sb_idx_i        (sb_idx),
        .sb_test_addrs_o (sb_test_addrs),
        .sb_test_en_o    (sb_test_en),
        .sb_collision_i  (sb_collision),
        .sb_full_i       (sb_full),
        .ex              (ex_if.issue)
    );

    fpss_scoreboard i_sb (
        .clk_i, .rst_n_i,
        .push_valid_i (sb_push),
        .push_addr_i  (sb_push_addr),
        .push_idx_o   (sb_idx),
        .test_addrs_i (sb_test_addrs),
        .test_en_i    (sb_test_en),
        .collision_o  (sb_collision),
        .full_o       (sb_full),
        .wb           (wb_if.dst)
    );

    fpss_regfile i_rf (
        .clk_i, .rst_n_i,
        .raddr_a_i (raddr_a),
        .raddr_b_i (raddr_b),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .wb        (wb_if.dst)
    );

    fpss_exec_pipe i_exec (
        .clk_i, .rst_n_i,
        .ex (ex_if.exec),
        .wb (wb_if.src),
        .acc_rsp_id_o, .acc_rsp_data_o, .acc_rsp_error_o,
        .acc_rsp_valid_o, .acc_rsp_ready_i
    );

endmodule

//--- src/fpss_exec_pipe.sv
`timescale 1ns/1ps

module fpss_exec_pipe (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    fpss_exec_if.exec                 ex,
    fpss_wb_if.src                    wb,
    output logic [fpss_pkg::ID_W-1:0] acc_rsp_id_o,
    output logic [fpss_pkg::XLEN-1:0] acc_rsp_data_o,
    output logic                      acc_rsp_error_o,
    output logic                      acc_rsp_valid_o,
    input  logic                      acc_rsp_ready_i
);
    import fpss_pkg::*;

    fpss_reg_u                         res;
    logic                              run_q;
    logic                              advance;
    logic [2:0]                        s_valid;
    logic [2:0]                        s_wr;
    logic [2:0]                        s_err;
    fpss_reg_u [2:0]                   s_data;
    logic [2:0][PADDR_W-1:0]           s_rd;
    logic [2:0][ID_W-1:0]              s_id;
    logic [2:0][SB_IDX_W-1:0]          s_idx;

    // Magnitude always comes from rs1
    always_comb begin
        res = ex.a;
        case (ex.op)
            OP_FSGNJ:   res.f.sign = ex.b.f.sign;
            OP_FSGNJN:  res.f.sign = ~ex.b.f.sign;
            OP_FSGNJX:  res.f.sign = ex.a.f.sign ^ ex.b.f.sign;
            OP_FMV_W_X: res.raw = {{(FLEN-XLEN){1'b1}}, ex.arg};
            default:    res = ex.a;
        endcase
    end

    // ------------------------------------------------------------------
    // Lock-step stages, all hold on response back-pressure
    // ------------------------------------------------------------------
    assign advance  = ~s_valid[2] | acc_rsp_ready_i;
    assign ex.ready = run_q & advance;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_q   <= 1'b0;
            s_valid <= '0;
        end else begin
            run_q <= 1'b1;
            if (advance) begin
                s_valid <= {s_valid[1:0], ex.valid & ex.ready};
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            s_wr   <= {s_wr[1:0], ~ex.error & (ex.op != OP_FMV_X_W)};
            s_err  <= {s_err[1:0], ex.error};
            s_data <= {s_data[1:0], res};
            s_rd   <= {s_rd[1:0], ex.rd_addr};
            s_id   <= {s_id[1:0], ex.id};
            s_idx  <= {s_idx[1:0], ex.sb_idx};
        end
    end

    // Response from the last stage
    assign acc_rsp_valid_o = s_valid[2];
    assign acc_rsp_id_o    = s_id[2];
    assign acc_rsp_error_o = s_err[2];
    assign acc_rsp_data_o  = s_err[2] ? '0 : s_data[2].raw[XLEN-1:0];

    // Writeback on the transfer edge
    assign wb.valid   = s_valid[2] & acc_rsp_ready_i & s_wr[2];
    assign wb.rd_addr = s_rd[2];
    assign wb.data    = s_data[2];
    assign wb.sb_idx  = s_idx[2];

endmodule

//--- src/fpss_issue.sv
`timescale 1ns/1ps

module fpss_issue (
    input  logic [31:0]                       acc_req_instr_i,
    input  logic [fpss_pkg::ID_W-1:0]         acc_req_id_i,
    input  logic [fpss_pkg::XLEN-1:0]         acc_req_arg_i,
    input  logic                              acc_req_valid_i,
    output logic                              acc_req_ready_o,
    input  logic [fpss_pkg::NUM_OFFS-1:0][fpss_pkg::OFFS_W-1:0] offsets_i,
    output logic [fpss_pkg::PADDR_W-1:0]      raddr_a_o,
    output logic [fpss_pkg::PADDR_W-1:0]      raddr_b_o,
    input  fpss_pkg::fpss_reg_u               rdata_a_i,
    input  fpss_pkg::fpss_reg_u               rdata_b_i,
    output logic                              sb_push_o,
    output logic [fpss_pkg::PADDR_W-1:0]      sb_push_addr_o,
    input  logic [fpss_pkg::SB_IDX_W-1:0]     sb_idx_i,
    output logic [2:0][fpss_pkg::PADDR_W-1:0] sb_test_addrs_o,
    output logic [2:0]                        sb_test_en_o,
    input  logic                              sb_collision_i,
    input  logic                              sb_full_i,
    fpss_exec_if.issue                        ex
);
    import fpss_pkg::*;

    logic [OP_W-1:0]    op;
    logic [PADDR_W-1:0] rd_addr;
    logic [PADDR_W-1:0] rs1_addr;
    logic [PADDR_W-1:0] rs2_addr;
    logic               legal;
    logic               writes_rd;
    logic               issue_ok;

    // Name bits 4:3 pick the offset, bits 2:0 pass through
    function automatic logic [PADDR_W-1:0] translate(
        input logic [NUM_OFFS-1:0][OFFS_W-1:0] offs,
        input logic [NAME_W-1:0]               name
    );
        return {offs[name[NAME_W-1:NAME_W-2]], name[NAME_W-3:0]};
    endfunction

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    assign op       = acc_req_instr_i[OP_LSB +: OP_W];
    assign rd_addr  = translate(offsets_i, acc_req_instr_i[RD_LSB +: NAME_W]);
    assign rs1_addr = translate(offsets_i, acc_req_instr_i[RS1_LSB +: NAME_W]);
    assign rs2_addr = translate(offsets_i, acc_req_instr_i[RS2_LSB +: NAME_W]);

    // Test enables are rs1, rs2, rd from bit 0 up
    always_comb begin
        legal        = 1'b1;
        sb_test_en_o = 3'b000;
        case (op)
            OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: sb_test_en_o = 3'b111;
            OP_FMV_W_X:                     sb_test_en_o = 3'b100;
            OP_FMV_X_W:                     sb_test_en_o = 3'b001;
            default:                        legal = 1'b0;
        endcase
    end

    assign writes_rd = legal & (op != OP_FMV_X_W);

    // ------------------------------------------------------------------
    // Hazard stall and scoreboard push
    // ------------------------------------------------------------------
    assign sb_test_addrs_o = {rd_addr, rs2_addr, rs1_addr};
    assign issue_ok        = ~sb_full_i & ~sb_collision_i;
    assign acc_req_ready_o = ex.ready & issue_ok;

    assign sb_push_o      = acc_req_valid_i & acc_req_ready_o & writes_rd;
    assign sb_push_addr_o = rd_addr;

    assign raddr_a_o = rs1_addr;
    assign raddr_b_o = rs2_addr;

    // Towards execute
    assign ex.valid   = acc_req_valid_i & issue_ok;
    assign ex.op      = op;
    assign ex.a       = rdata_a_i;
    assign ex.b       = rdata_b_i;
    assign ex.arg     = acc_req_arg_i;
    assign ex.rd_addr = rd_addr;
    assign ex.id      = acc_req_id_i;
    assign ex.sb_idx  = sb_idx_i;
    assign ex.error   = ~legal;

endmodule

//--- src/fpss_regfile.sv
`timescale 1ns/1ps

module fpss_regfile (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic [fpss_pkg::PADDR_W-1:0] raddr_a_i,
    input  logic [fpss_pkg::PADDR_W-1:0] raddr_b_i,
    output fpss_pkg::fpss_reg_u          rdata_a_o,
    output fpss_pkg::fpss_reg_u          rdata_b_o,
    fpss_wb_if.dst                       wb
);
    import fpss_pkg::*;

    fpss_reg_u mem [2**PADDR_W];

    // Improperly boxed words read as canonical NaN
    function automatic fpss_reg_u unbox(input fpss_reg_u w);
        fpss_reg_u r;
        r = w;
        if (w.f.box != '1) begin
            r.raw = {{(FLEN-XLEN){1'b1}}, CANON_NAN};
        end
        return r;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**PADDR_W; i++) begin
                mem[i] <= '0;
            end
        end else if (wb.valid) begin
            mem[wb.rd_addr] <= wb.data;
        end
    end

    assign rdata_a_o = unbox(mem[raddr_a_i]);
    assign rdata_b_o = unbox(mem[raddr_b_i]);

endmodule

//--- src/fpss_scoreboard.sv
`timescale 1ns/1ps

module fpss_scoreboard (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 push_valid_i,
    input  logic [fpss_pkg::PADDR_W-1:0]         push_addr_i,
    output logic [fpss_pkg::SB_IDX_W-1:0]        push_idx_o,
    input  logic [2:0][fpss_pkg::PADDR_W-1:0]    test_addrs_i,
    input  logic [2:0]                           test_en_i,
    output logic                                 collision_o,
    output logic                                 full_o,
    fpss_wb_if.dst                               wb
);
    import fpss_pkg::*;

    logic [SB_DEPTH-1:0]              ent_valid;
    logic [SB_DEPTH-1:0][PADDR_W-1:0] ent_addr;

    // Lowest free entry wins
    always_comb begin
        push_idx_o = '0;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                push_idx_o = SB_IDX_W'(i);
            end
        end
    end

    assign full_o = &ent_valid;

    always_comb begin
        collision_o = 1'b0;
        for (int t = 0; t < 3; t++) begin
            for (int e = 0; e < SB_DEPTH; e++) begin
                if (test_en_i[t] && ent_valid[e] && ent_addr[e] == test_addrs_i[t]) begin
                    collision_o = 1'b1;
                end
            end
        end
    end

    // Pop and push never hit the same entry
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ent_valid <= '0;
        end else begin
            if (wb.valid) begin
                ent_valid[wb.sb_idx] <= 1'b0;
            end
            if (push_valid_i) begin
                ent_valid[push_idx_o] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_valid_i) begin
            ent_addr[push_idx_o] <= push_addr_i;
        end
    end

endmodule

//--- src/fpss_cfg_apb.sv
`timescale 1ns/1ps

module fpss_cfg_apb (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [fpss_pkg::CFG_ADDR_W-1:0]  paddr_i,
    input  logic                             psel_i,
    input  logic                             penable_i,
    input  logic                             pwrite_i,
    input  logic [31:0]                      pwdata_i,
    output logic [31:0]                      prdata_o,
    output logic                             pready_o,
    output logic                             pslverr_o,
    output logic [fpss_pkg::NUM_OFFS-1:0][fpss_pkg::OFFS_W-1:0] offsets_o
);
    import fpss_pkg::*;

    logic addr_ok;
    logic wr_en;

    // Only word-aligned addresses are mapped
    assign addr_ok = (paddr_i[1:0] == 2'b00);

    // No wait states
    assign pready_o  = psel_i & penable_i;
    assign wr_en     = pready_o & pwrite_i & addr_ok;
    assign pslverr_o = pready_o & pwrite_i & ~addr_ok;

    // Identity mapping out of reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < NUM_OFFS; k++) begin
                offsets_o[k] <= OFFS_W'(k);
            end
        end else if (wr_en) begin
            offsets_o[paddr_i[CFG_ADDR_W-1:2]] <= pwdata_i[OFFS_W-1:0];
        end
    end

    always_comb begin
        prdata_o = '0;
        if (addr_ok) begin
            prdata_o[OFFS_W-1:0] = offsets_o[paddr_i[CFG_ADDR_W-1:2]];
        end
    end

endmodule

//--- src/fpss_wb_if.sv
`timescale 1ns/1ps

interface fpss_wb_if;
    import fpss_pkg::*;

    logic                valid;
    logic [PADDR_W-1:0]  rd_addr;
    fpss_reg_u           data;
    logic [SB_IDX_W-1:0] sb_idx;

    modport src (output valid, rd_addr, data, sb_idx);

    // Register file and scoreboard both listen
    modport dst (input valid, rd_addr, data, sb_idx);

endinterface

//--- src/fpss_exec_if.sv
`timescale 1ns/1ps

interface fpss_exec_if;
    import fpss_pkg::*;

    logic                valid;
    logic                ready;
    logic [OP_W-1:0]     op;
    fpss_reg_u           a;
    fpss_reg_u           b;
    logic [XLEN-1:0]     arg;
    logic [PADDR_W-1:0]  rd_addr;
    logic [ID_W-1:0]     id;
    logic [SB_IDX_W-1:0] sb_idx;
    logic                error;

    modport issue (
        output valid, op, a, b, arg, rd_addr, id, sb_idx, error,
        input  ready
    );

    modport exec (
        input  valid, op, a, b, arg, rd_addr, id, sb_idx, error,
        output ready
    );

endinterface

//--- src/fpss_pkg.sv
package fpss_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int FLEN       = 64;
    localparam int NAME_W     = 5;
    localparam int PADDR_W    = 6;
    localparam int OFFS_W     = 3;
    localparam int NUM_OFFS   = 4;
    localparam int SB_DEPTH   = 4;
    localparam int SB_IDX_W   = 2;
    localparam int ID_W       = 5;
    localparam int OP_W       = 4;
    localparam int CFG_ADDR_W = 4;

    // ------------------------------------------------------------------
    // Opcodes, everything else is illegal
    // ------------------------------------------------------------------
    localparam logic [OP_W-1:0] OP_FSGNJ   = 4'd1;
    localparam logic [OP_W-1:0] OP_FSGNJN  = 4'd2;
    localparam logic [OP_W-1:0] OP_FSGNJX  = 4'd3;
    localparam logic [OP_W-1:0] OP_FMV_W_X = 4'd4;
    localparam logic [OP_W-1:0] OP_FMV_X_W = 4'd5;

    // Low bit of each instruction field
    localparam int OP_LSB  = 28;
    localparam int RD_LSB  = 23;
    localparam int RS1_LSB = 18;
    localparam int RS2_LSB = 13;

    localparam logic [XLEN-1:0] CANON_NAN = 32'h7FC0_0000;

    // Register word, raw or as a NaN-boxed single
    typedef union packed {
        logic [FLEN-1:0] raw;
        struct packed {
            logic [FLEN-XLEN-1:0] box;
            logic                 sign;
            logic [7:0]           exp;
            logic [22:0]          mant;
        } f;
    } fpss_reg_u;

endpackage
